// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_core_boundary
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rtl/core_pkg.sv
rtl/pipe_reg.sv
rtl/dma_router.sv
rtl/core_mem.sv
rtl/core_ctrl_regs.sv
rtl/desc_engine.sv
rtl/core_boundary.sv
sim/tb_core_boundary.sv

// ==== rtl/core_boundary.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_boundary (
  input  logic                                 sys_clk,
  input  logic                                 reset,
  input  logic                                 core_reset,
  input  logic [core_pkg::CORE_ID_WIDTH-1:0]   core_id,
  input  logic                                 core_interrupt,
  output logic                                 core_interrupt_ack,

  input  logic                                 dma_cmd_wr_en,
  input  logic [core_pkg::DMA_ADDR_WIDTH-1:0]  dma_cmd_wr_addr,
  input  logic [core_pkg::DATA_WIDTH-1:0]      dma_cmd_wr_data,
  input  logic [core_pkg::STRB_WIDTH-1:0]      dma_cmd_wr_strb,
  output logic                                 dma_cmd_wr_ready,

  input  logic                                 dma_cmd_rd_en,
  input  logic [core_pkg::DMA_ADDR_WIDTH-1:0]  dma_cmd_rd_addr,
  output logic                                 dma_cmd_rd_ready,

  output logic                                 dma_rd_resp_valid,
  output logic [core_pkg::DATA_WIDTH-1:0]      dma_rd_resp_data,
  input  logic                                 dma_rd_resp_ready,

  input  logic [core_pkg::DESC_WIDTH-1:0]      in_desc,
  input  logic                                 in_desc_valid,
  output logic                                 in_desc_taken,

  output logic [core_pkg::DESC_WIDTH-1:0]      out_desc,
  output logic [core_pkg::DRAM_ADDR_WIDTH-1:0] out_desc_dram_addr,
  output logic                                 out_desc_valid,
  input  logic                                 out_desc_ready
);
  import core_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Registered resets and interrupt
  //////////////////////////////////////////////////////////////////////
  logic                     reset_r;
  logic                     core_reset_r;
  logic [CORE_ID_WIDTH-1:0] core_id_r;
  logic                     core_interrupt_r;
  logic                     core_interrupt_ack_n;
  logic                     desc_reset;

  always_ff @(posedge sys_clk) begin
    reset_r            <= reset;
    core_reset_r       <= core_reset;
    core_id_r          <= core_id;
    core_interrupt_r   <= core_interrupt;
    core_interrupt_ack <= core_interrupt_ack_n;
  end

  // Descriptor path also clears on soft reset
  assign desc_reset = reset_r || core_reset_r;

  //////////////////////////////////////////////////////////////////////
  // Boundary pipe registers
  //////////////////////////////////////////////////////////////////////
  dma_wr_t                 wr_cmd_in;
  dma_wr_t                 wr_cmd_r;
  logic                    wr_valid_r;
  logic                    wr_ready_r;
  dma_rd_t                 rd_cmd_in;
  dma_rd_t                 rd_cmd_r;
  logic                    rd_valid_r;
  logic                    rd_ready_r;
  logic [DATA_WIDTH-1:0]   resp_data_n;
  logic                    resp_valid_n;
  logic                    resp_ready_n;
  logic [DESC_WIDTH-1:0]   in_desc_r;
  logic                    in_desc_valid_r;
  logic                    in_desc_taken_r;
  out_desc_t               out_desc_n;
  out_desc_t               out_desc_q;
  logic                    out_desc_valid_n;
  logic                    out_desc_ready_n;

  assign wr_cmd_in.addr     = dma_cmd_wr_addr;
  assign wr_cmd_in.data     = dma_cmd_wr_data;
  assign wr_cmd_in.strb     = dma_cmd_wr_strb;
  assign rd_cmd_in.addr     = dma_cmd_rd_addr;
  assign out_desc           = out_desc_q.desc;
  assign out_desc_dram_addr = out_desc_q.dram_addr;

  pipe_reg #(.payload_t(dma_wr_t), .STAGES(PIPE_STAGES)) u_dma_wr_pipe (
    .sys_clk(sys_clk), .reset(reset_r),
    .s_data(wr_cmd_in), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_cmd_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.payload_t(dma_rd_t), .STAGES(PIPE_STAGES)) u_dma_rd_pipe (
    .sys_clk(sys_clk), .reset(reset_r),
    .s_data(rd_cmd_in), .s_valid(dma_cmd_rd_en), .s_ready(dma_cmd_rd_ready),
    .m_data(rd_cmd_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.payload_t(logic [DATA_WIDTH-1:0]), .STAGES(PIPE_STAGES)) u_rd_resp_pipe (
    .sys_clk(sys_clk), .reset(reset_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid), .m_ready(dma_rd_resp_ready)
  );

  pipe_reg #(.payload_t(logic [DESC_WIDTH-1:0]), .STAGES(PIPE_STAGES)) u_in_desc_pipe (
    .sys_clk(sys_clk), .reset(desc_reset),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_taken_r)
  );

  pipe_reg #(.payload_t(out_desc_t), .STAGES(PIPE_STAGES)) u_out_desc_pipe (
    .sys_clk(sys_clk), .reset(desc_reset),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc_q), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Core units
  //////////////////////////////////////////////////////////////////////
  logic                        mem_wr_en;
  logic                        mem_rd_en;
  logic [LINE_IDX_WIDTH-1:0]   mem_line;
  logic [DATA_WIDTH-1:0]       mem_wdata;
  logic [STRB_WIDTH-1:0]       mem_strb;
  logic [DATA_WIDTH-1:0]       mem_rdata;
  logic                        reg_wr_en;
  logic                        reg_rd_en;
  logic [REG_IDX_WIDTH-1:0]    reg_idx;
  logic [DATA_WIDTH-1:0]       reg_rdata;
  logic [DRAM_ADDR_WIDTH-1:0]  dram_base;
  logic [DESC_COUNT_WIDTH-1:0] desc_count;

  dma_router u_dma_router (
    .sys_clk(sys_clk), .reset(reset_r),
    .wr_cmd(wr_cmd_r), .wr_valid(wr_valid_r), .wr_ready(wr_ready_r),
    .rd_cmd(rd_cmd_r), .rd_valid(rd_valid_r), .rd_ready(rd_ready_r),
    .resp_data(resp_data_n), .resp_valid(resp_valid_n), .resp_ready(resp_ready_n),
    .mem_wr_en(mem_wr_en), .mem_rd_en(mem_rd_en), .mem_line(mem_line),
    .mem_wdata(mem_wdata), .mem_strb(mem_strb), .mem_rdata(mem_rdata),
    .reg_wr_en(reg_wr_en), .reg_rd_en(reg_rd_en), .reg_idx(reg_idx),
    .reg_rdata(reg_rdata)
  );

  core_mem u_core_mem (
    .sys_clk(sys_clk),
    .mem_wr_en(mem_wr_en), .mem_rd_en(mem_rd_en), .mem_line(mem_line),
    .mem_wdata(mem_wdata), .mem_strb(mem_strb), .mem_rdata(mem_rdata)
  );

  // Register bank shares write data and strobe with the memory path
  core_ctrl_regs u_core_ctrl_regs (
    .sys_clk(sys_clk), .reset(reset_r),
    .reg_wr_en(reg_wr_en), .reg_rd_en(reg_rd_en), .reg_idx(reg_idx),
    .reg_wdata(mem_wdata), .reg_strb(mem_strb), .reg_rdata(reg_rdata),
    .desc_count(desc_count),
    .core_interrupt(core_interrupt_r), .core_interrupt_ack(core_interrupt_ack_n),
    .dram_base(dram_base)
  );

  desc_engine u_desc_engine (
    .sys_clk(sys_clk), .reset(reset_r), .core_reset(core_reset_r),
    .core_id(core_id_r), .dram_base(dram_base),
    .in_desc(in_desc_r), .in_valid(in_desc_valid_r), .in_taken(in_desc_taken_r),
    .out_desc(out_desc_n), .out_valid(out_desc_valid_n), .out_ready(out_desc_ready_n),
    .desc_count(desc_count)
  );

endmodule

`default_nettype wire

// ==== rtl/core_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_regs (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  logic                                  reg_wr_en,
  input  logic                                  reg_rd_en,
  input  logic [core_pkg::REG_IDX_WIDTH-1:0]    reg_idx,
  input  logic [core_pkg::DATA_WIDTH-1:0]       reg_wdata,
  input  logic [core_pkg::STRB_WIDTH-1:0]       reg_strb,
  output logic [core_pkg::DATA_WIDTH-1:0]       reg_rdata,
  input  logic [core_pkg::DESC_COUNT_WIDTH-1:0] desc_count,
  input  logic                                  core_interrupt,
  output logic                                  core_interrupt_ack,
  output logic [core_pkg::DRAM_ADDR_WIDTH-1:0]  dram_base
);
  import core_pkg::*;

  logic irq_en;
  logic irq_prev;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      dram_base <= '0;
      irq_en    <= 1'b0;
    end else if (reg_wr_en) begin
      if (reg_idx == REG_DRAM_BASE) begin
        for (int b = 0; b < DRAM_ADDR_WIDTH / 8; b++) begin
          if (reg_strb[b]) begin
            dram_base[b*8 +: 8] <= reg_wdata[b*8 +: 8];
          end
        end
      end
      if (reg_idx == REG_IRQ_EN && reg_strb[0]) begin
        irq_en <= reg_wdata[0];
      end
    end
  end

  // Zero-extended read, reserved index gives zero
  always_comb begin
    reg_rdata = '0;
    if (reg_rd_en) begin
      case (reg_idx)
        REG_DRAM_BASE:  reg_rdata = DATA_WIDTH'(dram_base);
        REG_IRQ_EN:     reg_rdata = DATA_WIDTH'(irq_en);
        REG_DESC_COUNT: reg_rdata = DATA_WIDTH'(desc_count);
        default:        reg_rdata = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Interrupt acknowledge
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      irq_prev           <= 1'b0;
      core_interrupt_ack <= 1'b0;
    end else begin
      irq_prev           <= core_interrupt;
      core_interrupt_ack <= irq_en && core_interrupt && !irq_prev;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/core_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_mem (
  input  logic                                sys_clk,
  input  logic                                mem_wr_en,
  input  logic                                mem_rd_en,
  input  logic [core_pkg::LINE_IDX_WIDTH-1:0] mem_line,
  input  logic [core_pkg::DATA_WIDTH-1:0]     mem_wdata,
  input  logic [core_pkg::STRB_WIDTH-1:0]     mem_strb,
  output logic [core_pkg::DATA_WIDTH-1:0]     mem_rdata
);
  import core_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_LINES];

  // Byte lanes written only where the strobe is set
  always_ff @(posedge sys_clk) begin
    if (mem_wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (mem_strb[b]) begin
          mem[mem_line][b*8 +: 8] <= mem_wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mem_rd_en) begin
      mem_rdata <= mem[mem_line];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // Datapath sizes
  localparam int DATA_WIDTH       = 128;
  localparam int STRB_WIDTH       = DATA_WIDTH / 8;
  localparam int DMA_ADDR_WIDTH   = 26;
  localparam int MEM_LINES        = 256;
  localparam int LINE_IDX_WIDTH   = $clog2(MEM_LINES);
  localparam int DESC_WIDTH       = 64;
  localparam int CORE_ID_WIDTH    = 4;
  localparam int DRAM_ADDR_WIDTH  = 64;
  localparam int DESC_COUNT_WIDTH = 32;
  localparam int PIPE_STAGES      = 2;

  // Address map
  localparam int REG_SPACE_BIT  = 25;
  localparam int REG_IDX_LSB    = 4;
  localparam int REG_IDX_WIDTH  = 2;
  localparam int DESC_ADDR_STEP = 16;

  // Register indices, index 3 reserved
  localparam logic [REG_IDX_WIDTH-1:0] REG_DRAM_BASE  = 2'd0;
  localparam logic [REG_IDX_WIDTH-1:0] REG_IRQ_EN     = 2'd1;
  localparam logic [REG_IDX_WIDTH-1:0] REG_DESC_COUNT = 2'd2;

  typedef struct packed {
    logic [DMA_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     data;
    logic [STRB_WIDTH-1:0]     strb;
  } dma_wr_t;

  typedef struct packed {
    logic [DMA_ADDR_WIDTH-1:0] addr;
  } dma_rd_t;

  typedef struct packed {
    logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
    logic [DESC_WIDTH-1:0]      desc;
  } out_desc_t;

endpackage

`default_nettype wire

// ==== rtl/desc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_engine (
  input  logic                                  sys_clk,
  input  logic                                  reset,
  input  logic                                  core_reset,
  input  logic [core_pkg::CORE_ID_WIDTH-1:0]    core_id,
  input  logic [core_pkg::DRAM_ADDR_WIDTH-1:0]  dram_base,
  input  logic [core_pkg::DESC_WIDTH-1:0]       in_desc,
  input  logic                                  in_valid,
  output logic                                  in_taken,
  output core_pkg::out_desc_t                   out_desc,
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic [core_pkg::DESC_COUNT_WIDTH-1:0] desc_count
);
  import core_pkg::*;

  logic accept;

  // One output holder, refilled while it drains
  assign in_taken = !out_valid || out_ready;
  assign accept   = in_valid && in_taken;

  always_ff @(posedge sys_clk) begin
    if (reset || core_reset) begin
      out_valid  <= 1'b0;
      desc_count <= '0;
    end else begin
      if (accept) begin
        out_valid  <= 1'b1;
        desc_count <= desc_count + 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // desc_count doubles as the sequence number of the next descriptor
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      out_desc.desc      <= {core_id, in_desc[DESC_WIDTH-CORE_ID_WIDTH-1:0]};
      out_desc.dram_addr <= dram_base + DRAM_ADDR_WIDTH'(desc_count)
                                      * DRAM_ADDR_WIDTH'(DESC_ADDR_STEP);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dma_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_router (
  input  logic                                sys_clk,
  input  logic                                reset,
  input  core_pkg::dma_wr_t                   wr_cmd,
  input  logic                                wr_valid,
  output logic                                wr_ready,
  input  core_pkg::dma_rd_t                   rd_cmd,
  input  logic                                rd_valid,
  output logic                                rd_ready,
  output logic [core_pkg::DATA_WIDTH-1:0]     resp_data,
  output logic                                resp_valid,
  input  logic                                resp_ready,
  output logic                                mem_wr_en,
  output logic                                mem_rd_en,
  output logic [core_pkg::LINE_IDX_WIDTH-1:0] mem_line,
  output logic [core_pkg::DATA_WIDTH-1:0]     mem_wdata,
  output logic [core_pkg::STRB_WIDTH-1:0]     mem_strb,
  input  logic [core_pkg::DATA_WIDTH-1:0]     mem_rdata,
  output logic                                reg_wr_en,
  output logic                                reg_rd_en,
  output logic [core_pkg::REG_IDX_WIDTH-1:0]  reg_idx,
  input  logic [core_pkg::DATA_WIDTH-1:0]     reg_rdata
);
  import core_pkg::*;

  logic rd_fire;
  logic mem_pend;

  // Writes land on the cycle they are accepted
  assign wr_ready  = 1'b1;
  assign mem_wr_en = wr_valid && !wr_cmd.addr[REG_SPACE_BIT];
  assign reg_wr_en = wr_valid && wr_cmd.addr[REG_SPACE_BIT];
  assign mem_wdata = wr_cmd.data;
  assign mem_strb  = wr_cmd.strb;

  // Single address port, so a read yields to a write
  assign rd_ready  = !wr_valid && !mem_pend && (!resp_valid || resp_ready);
  assign rd_fire   = rd_valid && rd_ready;
  assign mem_rd_en = rd_fire && !rd_cmd.addr[REG_SPACE_BIT];
  assign reg_rd_en = rd_fire && rd_cmd.addr[REG_SPACE_BIT];

  assign mem_line = wr_valid ? wr_cmd.addr[REG_IDX_LSB +: LINE_IDX_WIDTH]
                             : rd_cmd.addr[REG_IDX_LSB +: LINE_IDX_WIDTH];
  assign reg_idx  = wr_valid ? wr_cmd.addr[REG_IDX_LSB +: REG_IDX_WIDTH]
                             : rd_cmd.addr[REG_IDX_LSB +: REG_IDX_WIDTH];

  ////////////////////////////////////////////////////////////////////
  // Read response holder
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      mem_pend   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      mem_pend <= mem_rd_en;
      if (mem_pend || reg_rd_en) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;
      end
    end
  end

  // Memory data arrives a cycle late, registers right away
  always_ff @(posedge sys_clk) begin
    if (mem_pend) begin
      resp_data <= mem_rdata;
    end else if (reg_rd_en) begin
      resp_data <= reg_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic,
  parameter int  STAGES    = 2
) (
  input  logic     sys_clk,
  input  logic     reset,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t stg_data  [STAGES+1];
  logic     stg_valid [STAGES+1];
  logic     stg_ready [STAGES+1];

  assign stg_data[0]       = s_data;
  assign stg_valid[0]      = s_valid;
  assign s_ready           = stg_ready[0];
  assign m_data            = stg_data[STAGES];
  assign m_valid           = stg_valid[STAGES];
  assign stg_ready[STAGES] = m_ready;

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    payload_t main_data;
    payload_t skid_data;
    logic     main_valid;
    logic     skid_valid;
    logic     in_ready;
    logic     accept;
    logic     load;
    logic     skid_valid_nx;

    assign accept        = stg_valid[i] && in_ready;
    // Main register empty or draining downstream
    assign load          = stg_ready[i+1] || !main_valid;
    assign skid_valid_nx = load ? 1'b0 : (skid_valid || accept);

    always_ff @(posedge sys_clk) begin
      if (reset) begin
        main_valid <= 1'b0;
        skid_valid <= 1'b0;
        in_ready   <= 1'b0;
      end else begin
        if (load) begin
          main_valid <= skid_valid || accept;
        end
        skid_valid <= skid_valid_nx;
        in_ready   <= !skid_valid_nx;
      end
    end

    // Skid beat goes out first to keep order
    always_ff @(posedge sys_clk) begin
      if (load) begin
        main_data <= skid_valid ? skid_data : stg_data[i];
      end
      if (accept && !load) begin
        skid_data <= stg_data[i];
      end
    end

    assign stg_ready[i]   = in_ready;
    assign stg_data[i+1]  = main_data;
    assign stg_valid[i+1] = main_valid;
  end

endmodule

`default_nettype wire

// ==== sim/tb_core_boundary.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_boundary;
  import core_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 1;
  localparam int N_LINES      = 8;
  localparam int N_DESC       = 8;
  localparam int N_STREAM     = 8;
  // Register, interrupt and soft reset work counted as 40 extra beats
  localparam int TOTAL_BEATS  = 3 * N_LINES + N_DESC + 3 * N_STREAM + 40;
  localparam int BEAT_CYCLES  = 40;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TOTAL_BEATS * BEAT_CYCLES) * CLK_PERIOD;
  localparam logic [CORE_ID_WIDTH-1:0] CORE_ID = 4'ha;

  logic                       sys_clk;
  logic                       reset;
  logic                       core_reset;
  logic [CORE_ID_WIDTH-1:0]   core_id;
  logic                       core_interrupt;
  logic                       core_interrupt_ack;
  logic                       dma_cmd_wr_en;
  logic [DMA_ADDR_WIDTH-1:0]  dma_cmd_wr_addr;
  logic [DATA_WIDTH-1:0]      dma_cmd_wr_data;
  logic [STRB_WIDTH-1:0]      dma_cmd_wr_strb;
  logic                       dma_cmd_wr_ready;
  logic                       dma_cmd_rd_en;
  logic [DMA_ADDR_WIDTH-1:0]  dma_cmd_rd_addr;
  logic                       dma_cmd_rd_ready;
  logic                       dma_rd_resp_valid;
  logic [DATA_WIDTH-1:0]      dma_rd_resp_data;
  logic                       dma_rd_resp_ready;
  logic [DESC_WIDTH-1:0]      in_desc;
  logic                       in_desc_valid;
  logic                       in_desc_taken;
  logic [DESC_WIDTH-1:0]      out_desc;
  logic [DRAM_ADDR_WIDTH-1:0] out_desc_dram_addr;
  logic                       out_desc_valid;
  logic                       out_desc_ready;

  core_boundary u_core_boundary (.*);

  integer seed;
  integer bp_seed;
  integer bp_rnd;
  int     bp_mode = 0;
  int     errors  = 0;
  int     checks  = 0;

  // Shadow model of the core state
  logic [DATA_WIDTH-1:0]      mem_model [MEM_LINES];
  logic [DRAM_ADDR_WIDTH-1:0] base_model;
  logic                       irq_en_model;
  int                         desc_seq;
  logic [LINE_IDX_WIDTH-1:0]  used_lines [N_LINES];

  logic [DATA_WIDTH-1:0] rsp_exp[$];
  logic [DATA_WIDTH-1:0] rsp_got[$];
  logic [127:0]          odesc_exp[$];
  logic [127:0]          odesc_got[$];

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // Output readies: 0 free running, 1 held low, 2 random
  initial begin
    bp_seed           = 11;
    dma_rd_resp_ready = 1'b1;
    out_desc_ready    = 1'b1;
    forever begin
      @(posedge sys_clk);
      #DRIVE_DLY;
      case (bp_mode)
        0: begin
          dma_rd_resp_ready = 1'b1;
          out_desc_ready    = 1'b1;
        end
        1: begin
          dma_rd_resp_ready = 1'b0;
          out_desc_ready    = 1'b0;
        end
        default: begin
          bp_rnd            = $random(bp_seed);
          dma_rd_resp_ready = bp_rnd[0];
          out_desc_ready    = bp_rnd[1];
        end
      endcase
    end
  end

  always @(negedge sys_clk) begin
    if (dma_rd_resp_valid && dma_rd_resp_ready) begin
      rsp_got.push_back(dma_rd_resp_data);
    end
    if (out_desc_valid && out_desc_ready) begin
      odesc_got.push_back({out_desc_dram_addr, out_desc});
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [DATA_WIDTH-1:0] rand_data();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic [DMA_ADDR_WIDTH-1:0] mem_addr(input logic [LINE_IDX_WIDTH-1:0] line);
    mem_addr = '0;
    mem_addr[REG_IDX_LSB +: LINE_IDX_WIDTH] = line;
  endfunction

  function automatic logic [DMA_ADDR_WIDTH-1:0] reg_addr(input logic [REG_IDX_WIDTH-1:0] idx);
    reg_addr = '0;
    reg_addr[REG_SPACE_BIT] = 1'b1;
    reg_addr[REG_IDX_LSB +: REG_IDX_WIDTH] = idx;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] reg_expect(input logic [REG_IDX_WIDTH-1:0] idx);
    case (idx)
      REG_DRAM_BASE:  return {64'd0, base_model};
      REG_IRQ_EN:     return {127'd0, irq_en_model};
      REG_DESC_COUNT: return {96'd0, 32'(desc_seq)};
      default:        return '0;
    endcase
  endfunction

  // All drive tasks start and end just after a rising edge
  task automatic dma_write(input logic [DMA_ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    logic taken;
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr_addr = addr;
    dma_cmd_wr_data = data;
    dma_cmd_wr_strb = strb;
    do begin
      taken = dma_cmd_wr_ready;
      @(posedge sys_clk);
      #DRIVE_DLY;
    end while (!taken);
    dma_cmd_wr_en = 1'b0;
  endtask

  task automatic dma_read(input logic [DMA_ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] exp);
    logic taken;
    rsp_exp.push_back(exp);
    dma_cmd_rd_en   = 1'b1;
    dma_cmd_rd_addr = addr;
    do begin
      taken = dma_cmd_rd_ready;
      @(posedge sys_clk);
      #DRIVE_DLY;
    end while (!taken);
    dma_cmd_rd_en = 1'b0;
  endtask

  task automatic write_mem(input logic [LINE_IDX_WIDTH-1:0] line,
                           input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        mem_model[line][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    dma_write(mem_addr(line), data, strb);
  endtask

  task automatic write_reg(input logic [REG_IDX_WIDTH-1:0] idx,
                           input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    for (int b = 0; b < DRAM_ADDR_WIDTH / 8; b++) begin
      if (idx == REG_DRAM_BASE && strb[b]) begin
        base_model[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    if (idx == REG_IRQ_EN && strb[0]) begin
      irq_en_model = data[0];
    end
    dma_write(reg_addr(idx), data, strb);
  endtask

  task automatic send_desc(input logic [DESC_WIDTH-1:0] desc);
    logic                       taken;
    logic [DRAM_ADDR_WIDTH-1:0] exp_addr;
    exp_addr = base_model + 64'(desc_seq) * 64'(DESC_ADDR_STEP);
    odesc_exp.push_back({exp_addr, CORE_ID, desc[DESC_WIDTH-CORE_ID_WIDTH-1:0]});
    desc_seq++;
    in_desc       = desc;
    in_desc_valid = 1'b1;
    do begin
      taken = in_desc_taken;
      @(posedge sys_clk);
      #DRIVE_DLY;
    end while (!taken);
    in_desc_valid = 1'b0;
  endtask

  task automatic pulse_core_reset();
    core_reset = 1'b1;
    repeat (2) @(posedge sys_clk);
    #DRIVE_DLY;
    core_reset = 1'b0;
    desc_seq   = 0;
    repeat (3) @(posedge sys_clk);
    #DRIVE_DLY;
  endtask

  // Wait for every expected item, then make sure nothing extra follows
  task automatic drain_and_compare();
    logic [127:0] got_d;
    logic [127:0] exp_d;
    while (rsp_got.size() < rsp_exp.size() || odesc_got.size() < odesc_exp.size()) begin
      @(posedge sys_clk);
    end
    repeat (10) @(posedge sys_clk);
    #DRIVE_DLY;
    check("read response count", 128'(rsp_got.size()), 128'(rsp_exp.size()));
    check("descriptor count", 128'(odesc_got.size()), 128'(odesc_exp.size()));
    while (rsp_got.size() > 0 && rsp_exp.size() > 0) begin
      check("dma_rd_resp_data", rsp_got.pop_front(), rsp_exp.pop_front());
    end
    while (odesc_got.size() > 0 && odesc_exp.size() > 0) begin
      got_d = odesc_got.pop_front();
      exp_d = odesc_exp.pop_front();
      check("out_desc_dram_addr", 128'(got_d[127:64]), 128'(exp_d[127:64]));
      check("out_desc", 128'(got_d[63:0]), 128'(exp_d[63:0]));
    end
    rsp_got.delete();
    rsp_exp.delete();
    odesc_got.delete();
    odesc_exp.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic test_memory();
    for (int i = 0; i < N_LINES; i++) begin
      used_lines[i] = 8'($random(seed));
      write_mem(used_lines[i], rand_data(), '1);
    end
    for (int i = 0; i < N_LINES; i++) begin
      write_mem(used_lines[i], rand_data(), 16'($random(seed)));
    end
    pulse_core_reset();
    for (int i = 0; i < N_LINES; i++) begin
      dma_read(mem_addr(used_lines[i]), mem_model[used_lines[i]]);
    end
    drain_and_compare();
  endtask

  task automatic test_registers();
    write_reg(REG_DRAM_BASE, rand_data(), 16'h00ff);
    write_reg(REG_DRAM_BASE, rand_data(), 16'h0c35);
    write_reg(REG_IRQ_EN, 128'h1, 16'h0000);
    write_reg(REG_IRQ_EN, 128'h1, 16'h0001);
    write_reg(2'd3, rand_data(), '1);
    write_reg(REG_DESC_COUNT, rand_data(), '1);
    for (int i = 0; i < 4; i++) begin
      dma_read(reg_addr(2'(i)), reg_expect(2'(i)));
    end
    drain_and_compare();
  endtask

  task automatic test_descriptors();
    for (int i = 0; i < N_DESC; i++) begin
      send_desc({$random(seed), $random(seed)});
    end
    drain_and_compare();
    dma_read(reg_addr(REG_DESC_COUNT), reg_expect(REG_DESC_COUNT));
    drain_and_compare();
  endtask

  task automatic test_backpressure();
    logic [DESC_WIDTH-1:0]     descs [N_STREAM];
    logic [LINE_IDX_WIDTH-1:0] lines [N_STREAM];
    for (int i = 0; i < N_STREAM; i++) begin
      descs[i] = {$random(seed), $random(seed)};
      lines[i] = 8'($random(seed));
      write_mem(lines[i], rand_data(), '1);
    end
    bp_mode = 1;
    fork
      begin
        for (int i = 0; i < N_STREAM; i++) send_desc(descs[i]);
      end
      begin
        for (int i = 0; i < N_STREAM; i++) dma_read(mem_addr(lines[i]), mem_model[lines[i]]);
      end
      begin
        repeat (24) @(posedge sys_clk);
        #DRIVE_DLY;
        bp_mode = 2;
      end
    join
    drain_and_compare();
    bp_mode = 0;
  endtask

  task automatic test_interrupt();
    int acks;
    write_reg(REG_IRQ_EN, 128'h0, 16'h0001);
    dma_read(reg_addr(REG_IRQ_EN), reg_expect(REG_IRQ_EN));
    drain_and_compare();
    acks = 0;
    core_interrupt = 1'b1;
    repeat (10) begin
      @(posedge sys_clk);
      #DRIVE_DLY;
      if (core_interrupt_ack) acks++;
    end
    check("core_interrupt_ack pulses with irq_en clear", 128'(acks), 128'd0);
    core_interrupt = 1'b0;
    repeat (4) @(posedge sys_clk);
    #DRIVE_DLY;
    write_reg(REG_IRQ_EN, 128'h1, 16'h0001);
    dma_read(reg_addr(REG_IRQ_EN), reg_expect(REG_IRQ_EN));
    drain_and_compare();
    // Pulse lands on the third edge after the rise
    repeat (3) begin
      core_interrupt = 1'b1;
      for (int c = 1; c <= 6; c++) begin
        @(posedge sys_clk);
        #DRIVE_DLY;
        check("core_interrupt_ack", 128'(core_interrupt_ack), 128'(c == 3));
      end
      core_interrupt = 1'b0;
      repeat (3) begin
        @(posedge sys_clk);
        #DRIVE_DLY;
        check("core_interrupt_ack", 128'(core_interrupt_ack), 128'd0);
      end
    end
  endtask

  task automatic test_soft_reset();
    pulse_core_reset();
    dma_read(reg_addr(REG_DESC_COUNT), reg_expect(REG_DESC_COUNT));
    dma_read(reg_addr(REG_DRAM_BASE), reg_expect(REG_DRAM_BASE));
    dma_read(reg_addr(REG_IRQ_EN), reg_expect(REG_IRQ_EN));
    for (int i = 0; i < N_LINES; i++) begin
      dma_read(mem_addr(used_lines[i]), mem_model[used_lines[i]]);
    end
    send_desc({$random(seed), $random(seed)});
    drain_and_compare();
  endtask

  initial begin
    seed            = 11;
    base_model      = '0;
    irq_en_model    = 1'b0;
    desc_seq        = 0;
    reset           = 1'b1;
    core_reset      = 1'b0;
    core_id         = CORE_ID;
    core_interrupt  = 1'b0;
    dma_cmd_wr_en   = 1'b0;
    dma_cmd_wr_addr = '0;
    dma_cmd_wr_data = '0;
    dma_cmd_wr_strb = '0;
    dma_cmd_rd_en   = 1'b0;
    dma_cmd_rd_addr = '0;
    in_desc         = '0;
    in_desc_valid   = 1'b0;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #DRIVE_DLY;
    check("dma_rd_resp_valid in reset", 128'(dma_rd_resp_valid), 128'd0);
    check("out_desc_valid in reset", 128'(out_desc_valid), 128'd0);
    check("in_desc_taken in reset", 128'(in_desc_taken), 128'd0);
    check("core_interrupt_ack in reset", 128'(core_interrupt_ack), 128'd0);
    reset = 1'b0;
    repeat (4) @(posedge sys_clk);
    #DRIVE_DLY;
    check("dma_cmd_wr_ready after reset", 128'(dma_cmd_wr_ready), 128'd1);
    check("dma_cmd_rd_ready after reset", 128'(dma_cmd_rd_ready), 128'd1);
    test_memory();
    test_registers();
    test_descriptors();
    test_backpressure();
    test_interrupt();
    test_soft_reset();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
